// ==== hw/rvCoreCfg.svh ====
/* core configuration macros: data width, register count, reset PC
   and the RV32I major opcodes kept by the core */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

`define XLEN     32            // data and address width
`define NREGS    32            // x0..x31
`define RESET_PC 32'h0000_0000 // first fetch address

// major opcodes, inst[6:0]
`define OPC_ALUREG 7'b0110011 // rd <- rs1 op rs2
`define OPC_ALUIMM 7'b0010011 // rd <- rs1 op imm
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_AUIPC  7'b0010111
`define OPC_LUI    7'b0110111
`define OPC_SYSTEM 7'b1110011 // ecall/ebreak, stops the core

`endif

// ==== hw/rvCorePkg.sv ====
/* shared core types: instruction class and ALU op enums,
   packets between fetch, decode and execute, writeback and retire */
`include "rvCoreCfg.svh"

package rvCorePkg;

  typedef logic [$clog2(`NREGS)-1:0] regIdxT; // register index

  // instruction class, one per kept major opcode
  typedef enum logic [3:0] {
    clsAluReg,
    clsAluImm,
    clsBranch,
    clsJal,
    clsJalr,
    clsAuipc,
    clsLui,
    clsSystem,
    clsIllegal  // unknown opcode, retires as no-op
  } opClassE;

  // ALU op taken straight from funct3
  typedef enum logic [2:0] {
    aluAdd  = 3'b000, // add/sub
    aluSll  = 3'b001,
    aluSlt  = 3'b010,
    aluSltu = 3'b011,
    aluXor  = 3'b100,
    aluSrl  = 3'b101, // srl/sra
    aluOr   = 3'b110,
    aluAnd  = 3'b111
  } aluOpE;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [31:0]      inst;
  } fetchPktT;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    opClassE          opClass;
    aluOpE            aluOp;
    logic [2:0]       funct3;  // branch condition
    logic             arith;   // sub or sra
    logic [`XLEN-1:0] rs1Val;
    logic [`XLEN-1:0] rs2Val;
    logic [`XLEN-1:0] imm;
    regIdxT           rd;
  } decPktT;

  typedef struct packed {
    logic             wen;
    regIdxT           rd;
    logic [`XLEN-1:0] value;
  } wbT;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    regIdxT           rd;
    logic [`XLEN-1:0] value;
    logic             wen;
    logic             halt;
  } retireT;

  typedef struct packed {
    logic [`XLEN-1:0] addr;
  } imemReqT;

endpackage

// ==== hw/fetchStage.sv ====
/* fetch stage: PC register, imem request/response handshake,
   packet hold toward decode and redirect wait */
`timescale 1ns/10ps
`include "rvCoreCfg.svh"

module fetchStage (
  input  logic                clk,
  input  logic                resetn,
  output logic                imemReqValid,
  output rvCorePkg::imemReqT  imemReq,
  input  logic                imemReqReady,
  input  logic                imemRspValid,
  input  logic [31:0]         imemRsp,
  output logic                fetchValid,
  output rvCorePkg::fetchPktT fetchPkt,
  input  logic                fetchReady,
  input  logic                redirectValid,
  input  logic [`XLEN-1:0]    redirectPc
);

  typedef enum logic [2:0] {idle, request, waitRsp, hold, waitRedirect} fetchStateE;

  fetchStateE       state;
  logic [`XLEN-1:0] pc;
  logic [31:0]      instQ;      // fetched word
  logic             reqPending; // tracks the open imem transaction

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state <= idle;
      pc    <= `RESET_PC;
    end else begin
      case (state)
        idle:         state <= request; // first request one cycle out of reset
        request:      if (imemReqReady) state <= waitRsp;
        waitRsp:      if (imemRspValid) state <= hold;
        hold:         if (fetchReady) state <= waitRedirect;
        waitRedirect: if (redirectValid) begin
          pc    <= redirectPc; // next PC always comes from execute
          state <= request;
        end
        default:      state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == waitRsp && imemRspValid) instQ <= imemRsp;
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) reqPending <= 1'b0;
    else if (imemReqValid && imemReqReady) reqPending <= 1'b1;
    else if (imemRspValid) reqPending <= 1'b0;
  end

  assign imemReqValid = (state == request); // addr held while ready is low
  assign imemReq      = '{addr: pc};
  assign fetchValid   = (state == hold);
  assign fetchPkt     = '{pc: pc, inst: instQ}; // pc is stable until redirect

  // at most one imem request in flight
  aOneOutstanding: assert property (@(posedge clk) disable iff (!resetn)
    reqPending |-> !imemReqValid);

endmodule

// ==== hw/decodeStage.sv ====
/* decode stage: opcode classification, immediate formats,
   register file with write port from execute */
`timescale 1ns/10ps
`include "rvCoreCfg.svh"

module decodeStage (
  input  logic                clk,
  input  logic                resetn,
  input  logic                fetchValid,
  input  rvCorePkg::fetchPktT fetchPkt,
  output logic                fetchReady,
  output logic                decValid,
  output rvCorePkg::decPktT   decPkt,
  input  logic                decReady,
  input  rvCorePkg::wbT       wb
);

  logic [31:0]          inst;
  logic [6:0]           opcode;
  logic [2:0]           funct3;
  rvCorePkg::regIdxT    rs1Idx;
  rvCorePkg::regIdxT    rs2Idx;
  rvCorePkg::regIdxT    rdIdx;
  logic [`XLEN-1:0]     immI, immB, immU, immJ;
  logic [`XLEN-1:0]     imm;
  rvCorePkg::opClassE   opClass;
  logic                 arith;
  logic [`XLEN-1:0]     rs1Val, rs2Val;
  logic                 capture;
  logic [`XLEN-1:0]     regs [`NREGS]; // x0 kept at zero by the write guard

  assign inst   = fetchPkt.inst;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign rs1Idx = inst[19:15];
  assign rs2Idx = inst[24:20];
  assign rdIdx  = inst[11:7];

  // immediate formats, sign from inst[31]
  assign immI = {{21{inst[31]}}, inst[30:20]};
  assign immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      `OPC_ALUREG: opClass = rvCorePkg::clsAluReg;
      `OPC_ALUIMM: opClass = rvCorePkg::clsAluImm;
      `OPC_BRANCH: opClass = rvCorePkg::clsBranch;
      `OPC_JAL:    opClass = rvCorePkg::clsJal;
      `OPC_JALR:   opClass = rvCorePkg::clsJalr;
      `OPC_AUIPC:  opClass = rvCorePkg::clsAuipc;
      `OPC_LUI:    opClass = rvCorePkg::clsLui;
      `OPC_SYSTEM: opClass = rvCorePkg::clsSystem;
      default:     opClass = rvCorePkg::clsIllegal;
    endcase
  end

  always_comb begin
    case (opClass)
      rvCorePkg::clsAluImm, rvCorePkg::clsJalr: imm = immI;
      rvCorePkg::clsBranch:                     imm = immB;
      rvCorePkg::clsJal:                        imm = immJ;
      rvCorePkg::clsAuipc, rvCorePkg::clsLui:   imm = immU;
      default:                                  imm = '0; // alu reg, system
    endcase
  end

  // inst[30] means sub/sra for reg ops, only srai for imm ops (addi uses it as imm bit)
  assign arith = (opClass == rvCorePkg::clsAluReg) ? inst[30] :
                 (opClass == rvCorePkg::clsAluImm && funct3 == 3'b101) ? inst[30] : 1'b0;

  assign rs1Val = regs[rs1Idx];
  assign rs2Val = regs[rs2Idx];

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < `NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wen && wb.rd != '0) begin
      regs[wb.rd] <= wb.value; // x0 writes dropped
    end
  end

  assign fetchReady = !decValid || decReady;
  assign capture    = fetchValid && fetchReady;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) decValid <= 1'b0;
    else if (fetchReady) decValid <= fetchValid; // hold while execute stalls
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      decPkt.pc      <= fetchPkt.pc;
      decPkt.opClass <= opClass;
      decPkt.aluOp   <= rvCorePkg::aluOpE'(funct3);
      decPkt.funct3  <= funct3;
      decPkt.arith   <= arith;
      decPkt.rs1Val  <= rs1Val;
      decPkt.rs2Val  <= rs2Val;
      decPkt.imm     <= imm;
      decPkt.rd      <= rdIdx;
    end
  end

  // x0 stays zero whatever execute wrote before
  aZeroReg: assert property (@(posedge clk) disable iff (!resetn)
    regs[0] == '0);

endmodule

// ==== hw/executeStage.sv ====
/* execute stage: ALU with shared subtractor and single right shifter,
   branch compare, next PC, writeback/retire registers, halt */
`timescale 1ns/10ps
`include "rvCoreCfg.svh"

module executeStage (
  input  logic              clk,
  input  logic              resetn,
  input  logic              decValid,
  input  rvCorePkg::decPktT decPkt,
  output logic              decReady,
  output rvCorePkg::wbT     wb,
  output logic              redirectValid,
  output logic [`XLEN-1:0]  redirectPc,
  output logic              retireValid,
  output rvCorePkg::retireT retire,
  output logic              halted
);

  // bit reversal so left shifts reuse the right shifter
  function automatic logic [`XLEN-1:0] flip(input logic [`XLEN-1:0] x);
    logic [`XLEN-1:0] y;
    for (int i = 0; i < `XLEN; i++) begin
      y[i] = x[`XLEN-1-i];
    end
    return y;
  endfunction

  logic [`XLEN-1:0] aluIn1, aluIn2, aluPlus, aluOut;
  logic [`XLEN:0]   aluMinus; // extra msb is the unsigned borrow
  logic [`XLEN-1:0] shIn;
  logic [`XLEN:0]   shWide;
  logic             shFill;
  logic             eq, lt, ltu, taken;
  logic [`XLEN-1:0] pcPlus4, pcPlusImm, nextPc, wbValue;
  logic             wen, isSystem, fire;

  assign aluIn1 = decPkt.rs1Val;
  assign aluIn2 = (decPkt.opClass == rvCorePkg::clsAluReg ||
                   decPkt.opClass == rvCorePkg::clsBranch) ? decPkt.rs2Val : decPkt.imm;

  assign aluPlus  = aluIn1 + aluIn2;
  assign aluMinus = {1'b0, aluIn1} - {1'b0, aluIn2}; // one subtractor for sub and compares
  assign eq       = (aluMinus[`XLEN-1:0] == '0);
  assign ltu      = aluMinus[`XLEN];
  assign lt       = (aluIn1[`XLEN-1] ^ aluIn2[`XLEN-1]) ? aluIn1[`XLEN-1] : aluMinus[`XLEN];

  // sll: flip, shift right, flip back; sra fills with the sign bit
  assign shIn   = (decPkt.aluOp == rvCorePkg::aluSll) ? flip(aluIn1) : aluIn1;
  assign shFill = decPkt.arith & (decPkt.aluOp == rvCorePkg::aluSrl) & aluIn1[`XLEN-1];
  assign shWide = $signed({shFill, shIn}) >>> aluIn2[$clog2(`XLEN)-1:0];

  always_comb begin
    case (decPkt.aluOp)
      rvCorePkg::aluAdd:  aluOut = decPkt.arith ? aluMinus[`XLEN-1:0] : aluPlus;
      rvCorePkg::aluSll:  aluOut = flip(shWide[`XLEN-1:0]);
      rvCorePkg::aluSlt:  aluOut = {{(`XLEN-1){1'b0}}, lt};
      rvCorePkg::aluSltu: aluOut = {{(`XLEN-1){1'b0}}, ltu};
      rvCorePkg::aluXor:  aluOut = aluIn1 ^ aluIn2;
      rvCorePkg::aluSrl:  aluOut = shWide[`XLEN-1:0]; // srl or sra
      rvCorePkg::aluOr:   aluOut = aluIn1 | aluIn2;
      default:            aluOut = aluIn1 & aluIn2;
    endcase
  end

  always_comb begin
    case (decPkt.funct3)
      3'b000:  taken = eq;   // beq
      3'b001:  taken = !eq;  // bne
      3'b100:  taken = lt;   // blt
      3'b101:  taken = !lt;  // bge
      3'b110:  taken = ltu;  // bltu
      3'b111:  taken = !ltu; // bgeu
      default: taken = 1'b0;
    endcase
  end

  assign pcPlus4   = decPkt.pc + `XLEN'd4;
  assign pcPlusImm = decPkt.pc + decPkt.imm;

  always_comb begin
    wen     = 1'b0;
    wbValue = aluOut;
    nextPc  = pcPlus4;
    case (decPkt.opClass)
      rvCorePkg::clsAluReg, rvCorePkg::clsAluImm: wen = 1'b1;
      rvCorePkg::clsBranch: if (taken) nextPc = pcPlusImm;
      rvCorePkg::clsJal: begin
        wen     = 1'b1;
        wbValue = pcPlus4; // link
        nextPc  = pcPlusImm;
      end
      rvCorePkg::clsJalr: begin
        wen     = 1'b1;
        wbValue = pcPlus4;
        nextPc  = {aluPlus[`XLEN-1:1], 1'b0}; // rs1+imm, bit 0 cleared
      end
      rvCorePkg::clsAuipc: begin
        wen     = 1'b1;
        wbValue = pcPlusImm;
      end
      rvCorePkg::clsLui: begin
        wen     = 1'b1;
        wbValue = decPkt.imm;
      end
      default: ; // system and unknown opcodes write nothing
    endcase
  end

  assign isSystem = (decPkt.opClass == rvCorePkg::clsSystem);
  assign decReady = !halted; // accept every cycle until halt
  assign fire     = decValid && decReady;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      retireValid   <= 1'b0;
      redirectValid <= 1'b0;
      halted        <= 1'b0;
    end else begin
      retireValid   <= fire;
      redirectValid <= fire && !isSystem; // no redirect freezes fetch on halt
      if (fire && isSystem) halted <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      redirectPc   <= nextPc;
      retire.pc    <= decPkt.pc;
      retire.rd    <= decPkt.rd;
      retire.value <= wbValue;
      retire.wen   <= wen;
      retire.halt  <= isSystem;
    end
  end

  // register write lands at the end of the retire cycle
  assign wb = '{wen: retireValid && retire.wen, rd: retire.rd, value: retire.value};

  aNoRedirectHalted: assert property (@(posedge clk) disable iff (!resetn)
    halted |-> !redirectValid);

endmodule

// ==== hw/rvCore.sv ====
/* core top: fetch, decode and execute stages wired together */
`timescale 1ns/10ps
`include "rvCoreCfg.svh"

module rvCore (
  input  logic               clk,
  input  logic               resetn,
  output logic               imemReqValid,
  output rvCorePkg::imemReqT imemReq,
  input  logic               imemReqReady,
  input  logic               imemRspValid,
  input  logic [31:0]        imemRsp,
  output logic               retireValid,
  output rvCorePkg::retireT  retire,
  output logic               halted
);

  logic                fetchValid;  // fetch -> decode
  rvCorePkg::fetchPktT fetchPkt;
  logic                fetchReady;
  logic                decValid;    // decode -> execute
  rvCorePkg::decPktT   decPkt;
  logic                decReady;
  rvCorePkg::wbT       wb;          // execute -> register file
  logic                redirectValid;
  logic [`XLEN-1:0]    redirectPc;  // execute -> fetch

  fetchStage fetch0 (
    .clk, .resetn,
    .imemReqValid, .imemReq, .imemReqReady,
    .imemRspValid, .imemRsp,
    .fetchValid, .fetchPkt, .fetchReady,
    .redirectValid, .redirectPc
  );

  decodeStage decode0 (
    .clk, .resetn,
    .fetchValid, .fetchPkt, .fetchReady,
    .decValid, .decPkt, .decReady,
    .wb
  );

  executeStage execute0 (
    .clk, .resetn,
    .decValid, .decPkt, .decReady,
    .wb,
    .redirectValid, .redirectPc,
    .retireValid, .retire,
    .halted
  );

endmodule

// ==== tb/progRom.sv ====
/* instruction memory model with random ready stalls and response
   latency, loaded with the fixed test program */
`timescale 1ns/10ps
`include "rvCoreCfg.svh"

module progRom (
  input  logic               clk,
  input  logic               resetn,
  input  logic               imemReqValid,
  input  rvCorePkg::imemReqT imemReq,
  output logic               imemReqReady,
  output logic               imemRspValid,
  output logic [31:0]        imemRsp
);

  localparam int romWords = 64;

  logic [31:0] mem [romWords];
  logic        busy = 1'b0;  // one request being served
  logic [5:0]  rspIdx;
  int          waitLeft;     // cycles until the response

  // instruction encoders, immediates given as plain integers
  function automatic logic [31:0] rType(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OPC_ALUREG};
  endfunction

  function automatic logic [31:0] iType(int imm, int rs1, int f3, int rd, logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] bType(int off, int rs2, int rs1, int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], `OPC_BRANCH};
  endfunction

  function automatic logic [31:0] uType(int imm, int rd, logic [6:0] opc);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] jType(int off, int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `OPC_JAL};
  endfunction

  initial begin
    imemReqReady = 1'b0;
    imemRspValid = 1'b0;
    imemRsp      = '0;
    // unused words hold an unknown opcode tagged with their index
    for (int i = 0; i < romWords; i++) mem[i] = {i[24:0], 7'h7f};
    mem[0]  = uType(32'h80001, 1, `OPC_LUI);          // x1 = 0x80001000
    mem[1]  = iType(-2047, 1, 0, 1, `OPC_ALUIMM);     // x1 = 0x80000801, negative
    mem[2]  = uType(32'h12345, 2, `OPC_LUI);
    mem[3]  = iType(32'h678, 2, 0, 2, `OPC_ALUIMM);   // x2 = 0x12345678
    mem[4]  = iType(5, 0, 0, 3, `OPC_ALUIMM);         // x3 = 5, shift amount
    mem[5]  = rType(0, 2, 1, 0, 4);                   // add
    mem[6]  = rType(32, 2, 1, 0, 5);                  // sub
    mem[7]  = rType(0, 2, 1, 4, 6);                   // xor
    mem[8]  = rType(0, 2, 1, 6, 7);                   // or
    mem[9]  = rType(0, 2, 1, 7, 8);                   // and
    mem[10] = rType(0, 3, 2, 1, 9);                   // sll
    mem[11] = rType(0, 3, 1, 5, 10);                  // srl
    mem[12] = rType(32, 3, 1, 5, 11);                 // sra
    mem[13] = iType(-1, 2, 4, 13, `OPC_ALUIMM);       // xori
    mem[14] = iType(32'h7ff, 1, 7, 15, `OPC_ALUIMM);  // andi
    mem[15] = iType(31, 2, 1, 16, `OPC_ALUIMM);       // slli by 31
    mem[16] = iType(32'h407, 1, 5, 17, `OPC_ALUIMM);  // srai on negative x1
    mem[17] = iType(7, 1, 5, 18, `OPC_ALUIMM);        // srli
    mem[18] = rType(0, 2, 1, 2, 19);                  // slt, signed gives 1
    mem[19] = rType(0, 2, 1, 3, 20);                  // sltu, unsigned gives 0
    mem[20] = iType(-1, 2, 2, 21, `OPC_ALUIMM);       // slti
    mem[21] = iType(-1, 2, 3, 22, `OPC_ALUIMM);       // sltiu against 0xffffffff
    // taken branches skip the next word
    mem[22] = bType(8, 3, 3, 0);  // beq taken
    mem[24] = bType(8, 2, 1, 0);  // beq not taken
    mem[25] = bType(8, 2, 1, 1);  // bne taken
    mem[27] = bType(8, 3, 3, 1);  // bne not taken
    mem[28] = bType(8, 2, 1, 4);  // blt taken
    mem[30] = bType(8, 1, 2, 4);  // blt not taken
    mem[31] = bType(8, 1, 2, 5);  // bge taken
    mem[33] = bType(8, 2, 1, 5);  // bge not taken
    mem[34] = bType(8, 1, 2, 6);  // bltu taken
    mem[36] = bType(8, 2, 1, 6);  // bltu not taken
    mem[37] = bType(8, 2, 1, 7);  // bgeu taken
    mem[39] = bType(8, 1, 2, 7);  // bgeu not taken
    mem[40] = jType(12, 26);                          // jal over two words
    mem[41] = iType(7, 0, 0, 27, `OPC_ALUIMM);        // reached by the backward branch
    mem[42] = jType(12, 0);                           // jal with link to x0
    mem[43] = bType(-8, 0, 0, 0);                     // backward beq
    mem[45] = uType(1, 28, `OPC_AUIPC);
    mem[46] = iType(189, 0, 0, 29, `OPC_ALUIMM);      // odd base for jalr
    mem[47] = iType(8, 29, 0, 30, `OPC_JALR);         // target 197 lands on 196
    mem[49] = uType(32'habcde, 0, `OPC_LUI);          // write to x0
    mem[50] = rType(0, 3, 0, 0, 31);                  // x0 must read zero
    mem[52] = 32'h0000_0073;                          // ecall, word 51 is unknown
  end

  always @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      imemReqReady <= 1'b0;
      imemRspValid <= 1'b0;
      busy         <= 1'b0;
    end else begin
      imemReqReady <= (($urandom % 4) != 0); // stall about one cycle in four
      imemRspValid <= 1'b0;
      if (busy) begin
        if (waitLeft == 0) begin
          imemRspValid <= 1'b1;
          imemRsp      <= mem[rspIdx];
          busy         <= 1'b0;
        end else begin
          waitLeft <= waitLeft - 1;
        end
      end else if (imemReqValid && imemReqReady) begin
        busy     <= 1'b1;
        rspIdx   <= imemReq.addr[7:2];
        waitLeft <= int'($urandom % 4); // 1 to 4 cycle latency
      end
    end
  end

endmodule

// ==== tb/coreTb.sv ====
/* core testbench: clock, reset, ISA shadow model with assertions
   on the retire port, per-test reporting and timeout */
`timescale 1ns/10ps
`include "rvCoreCfg.svh"

module coreTb;

  localparam int resetCycles = 10;
  localparam int progWords   = 53;
  localparam int drainCycles = 20; // quiet period after halt
  localparam int cycleLimit  = resetCycles + progWords * 12 + drainCycles;
  localparam int nTests      = 6;

  logic               clk = 1'b0;
  logic               resetn = 1'b0;
  logic               imemReqValid;
  rvCorePkg::imemReqT imemReq;
  logic               imemReqReady;
  logic               imemRspValid;
  logic [31:0]        imemRsp;
  logic               retireValid;
  rvCorePkg::retireT  retire;
  logic               halted;

  logic [31:0] shadowReg [32] = '{default: '0};
  logic [31:0] shadowPc = `RESET_PC;
  logic        expWen, expHalt;
  logic [4:0]  expRd;
  logic [31:0] expVal, expNext;
  logic        haltRetired = 1'b0;

  int    errorCount = 0;
  int    testsFailed = 0;
  int    errAtStart = 0;
  int    curTest = 0;
  int    cycles = 0;
  int    sectionEnd [5] = '{12, 17, 21, 39, 51}; // last word of tests 1..5
  string testName [nTests] = '{"register alu", "immediate alu", "compares",
                               "branches", "jumps and upper immediates", "halt"};

  rvCore dut0 (
    .clk, .resetn,
    .imemReqValid, .imemReq, .imemReqReady,
    .imemRspValid, .imemRsp,
    .retireValid, .retire,
    .halted
  );

  progRom rom0 (
    .clk, .resetn,
    .imemReqValid, .imemReq, .imemReqReady,
    .imemRspValid, .imemRsp
  );

  initial begin
    forever #4 clk = ~clk;
  end

  task automatic reportMismatch(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
    errorCount++;
  endtask

  task automatic noteProblem(input string msg);
    $display("%0t ns: %s", $time, msg);
    errorCount++;
  endtask

  // RV32I rules applied to the shadow state
  task automatic predictRetire(input logic [31:0] inst, input logic [31:0] pc);
    logic [31:0] a, b, immI, immB, immU, immJ;
    logic [4:0]  sh;
    logic        cond;
    a    = shadowReg[inst[19:15]];
    b    = shadowReg[inst[24:20]];
    immI = {{20{inst[31]}}, inst[31:20]};
    immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    immU = {inst[31:12], 12'h000};
    immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    cond    = 1'b0;
    expRd   = inst[11:7];
    expWen  = 1'b1;
    expHalt = 1'b0;
    expVal  = '0;
    expNext = pc + 32'd4;
    case (inst[6:0])
      `OPC_LUI:   expVal = immU;
      `OPC_AUIPC: expVal = pc + immU;
      `OPC_JAL: begin
        expVal  = pc + 32'd4;
        expNext = pc + immJ;
      end
      `OPC_JALR: begin
        expVal  = pc + 32'd4;
        expNext = (a + immI) & ~32'd1;
      end
      `OPC_BRANCH: begin
        expWen = 1'b0;
        case (inst[14:12])
          3'd0:    cond = (a == b);
          3'd1:    cond = (a != b);
          3'd4:    cond = ($signed(a) < $signed(b));
          3'd5:    cond = ($signed(a) >= $signed(b));
          3'd6:    cond = (a < b);
          3'd7:    cond = (a >= b);
          default: cond = 1'b0;
        endcase
        if (cond) expNext = pc + immB;
      end
      `OPC_ALUREG, `OPC_ALUIMM: begin
        if (inst[6:0] == `OPC_ALUIMM) b = immI;
        sh = b[4:0];
        case (inst[14:12])
          3'd0: begin
            if (inst[6:0] == `OPC_ALUREG && inst[30]) expVal = a - b;
            else expVal = a + b;
          end
          3'd1: expVal = a << sh;
          3'd2: expVal = {31'b0, $signed(a) < $signed(b)};
          3'd3: expVal = {31'b0, a < b};
          3'd4: expVal = a ^ b;
          3'd5: begin
            if (inst[30]) expVal = $signed(a) >>> sh; // sra fills with sign
            else expVal = a >> sh;
          end
          3'd6: expVal = a | b;
          default: expVal = a & b;
        endcase
      end
      `OPC_SYSTEM: begin
        expWen  = 1'b0;
        expHalt = 1'b1;
        expNext = pc; // core stops here
      end
      default: expWen = 1'b0; // unknown opcode, no-op
    endcase
  endtask

  task automatic closeTest(input logic reached);
    int errs;
    errs = errorCount - errAtStart;
    if (reached && errs == 0) begin
      $display("test %0d %s: ok", curTest + 1, testName[curTest]);
    end else begin
      testsFailed++;
      if (!reached) $display("test %0d %s: its last instruction never retired",
                             curTest + 1, testName[curTest]);
      else $display("test %0d %s: failed with %0d errors", curTest + 1, testName[curTest], errs);
    end
    errAtStart = errorCount;
    curTest++;
  endtask

  always @(posedge clk) begin
    if (resetn && retireValid) begin
      predictRetire(rom0.mem[shadowPc[7:2]], shadowPc);
      aPc: assert (retire.pc == shadowPc)
        else reportMismatch("retire pc", retire.pc, shadowPc);
      aRd: assert (retire.rd == expRd)
        else reportMismatch("retire rd", 32'(retire.rd), 32'(expRd));
      aWen: assert (retire.wen == expWen)
        else reportMismatch("retire wen", 32'(retire.wen), 32'(expWen));
      aValue: assert (!expWen || retire.value == expVal)
        else reportMismatch($sformatf("value for x%0d", expRd), retire.value, expVal);
      aHaltBit: assert (retire.halt == expHalt)
        else reportMismatch("retire halt", 32'(retire.halt), 32'(expHalt));
      if (expHalt) begin
        aHalted: assert (halted) else noteProblem("halted did not rise with the ecall");
      end
      if (expWen && expRd != 5'd0) shadowReg[expRd] = expVal; // x0 stays zero
      if (retire.halt) haltRetired = 1'b1;
      if (curTest < nTests - 1) begin
        if (retire.pc == 32'(sectionEnd[curTest] * 4)) closeTest(1'b1);
      end
      shadowPc = expNext;
    end
  end

  // each fetch goes to the pc the ISA model expects next, held while stalled
  aFetchAddr: assert property (@(posedge clk) disable iff (!resetn)
    imemReqValid |-> imemReq.addr == shadowPc)
    else reportMismatch("imem request address", imemReq.addr, shadowPc);
  aQuietAfterHalt: assert property (@(posedge clk) disable iff (!resetn)
    halted |=> !retireValid) else noteProblem("an instruction retired after the halt");
  aNoFetchAfterHalt: assert property (@(posedge clk) disable iff (!resetn)
    halted |-> !imemReqValid) else noteProblem("fetch sent a request after the halt");

  // run limit from program length
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout: the core did not halt within %0d cycles", cycleLimit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(2483));
    repeat (resetCycles) @(posedge clk);
    resetn <= 1'b1;
    while (halted !== 1'b1) @(posedge clk);
    repeat (drainCycles) @(posedge clk); // let the post-halt checks run
    while (curTest < nTests - 1) closeTest(1'b0);
    closeTest(haltRetired);
    $display("tests run %0d, failed %0d, errors %0d", nTests, testsFailed, errorCount);
    if (errorCount == 0 && testsFailed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+hw
hw/rvCorePkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/rvCore.sv
tb/progRom.sv
tb/coreTb.sv

// ==== Makefile ====
TOP := coreTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sim.f

obj_dir/V$(TOP): sim.f hw/rvCoreCfg.svh $(shell grep -v '^+' sim.f)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@! grep -q "STATUS: FAIL" sim.log
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
